// ==== flist.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/pc_redirect.sv
hdl/if_stage.sv
hdl/inst_rom.sv
hdl/fetch_top.sv
sim/fetch_properties.sv
sim/tb_fetch.sv

// ==== hdl/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// pc held before the first fetch, the first request goes to this plus 4
`define FETCH_RESET_PC 32'h1bfffffc

// instruction rom geometry
`define IMEM_WORDS 16

// cycles from an accepted read to its data_ok
`define IMEM_LATENCY 2

// reads the rom keeps in flight before it drops addr_ok
`define IMEM_MAX_OUTSTANDING 2

// width of the stale response counter in the fetch stage
`define CANCEL_CNT_WIDTH 4

`endif

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // branch from decode
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    // exception entry and exception return from writeback
    typedef struct packed {
        logic        ertn_valid;
        logic        ex_valid;
        logic [31:0] ex_entry;
        logic [31:0] era;
    } csr_redirect_t;

    // fetched item handed to decode
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
    } if_to_id_t;

    // fetch side exceptions, address fault only for now
    typedef struct packed {
        logic adef;
    } if_excep_t;

endpackage

// ==== hdl/fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top (
    input  logic                     clk,
    input  logic                     resetn,
    input  fetch_pkg::redirect_t     br,
    input  logic                     br_stall,
    input  fetch_pkg::csr_redirect_t wb_csr,
    input  logic                     if_flush,
    input  logic                     id_allowin,
    output logic                     if_to_id_valid,
    output fetch_pkg::if_to_id_t     if_to_id,
    output fetch_pkg::if_excep_t     if_excep
);
    // instruction memory bus
    logic        inst_sram_req;
    logic [31:0] inst_sram_addr;
    logic        inst_sram_addr_ok;
    logic        inst_sram_data_ok;
    logic [31:0] inst_sram_rdata;

    if_stage i_if_stage (
        .clk               (clk),
        .resetn            (resetn),
        .id_allowin        (id_allowin),
        .br_stall          (br_stall),
        .if_flush          (if_flush),
        .br                (br),
        .wb_csr            (wb_csr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .if_to_id_valid    (if_to_id_valid),
        .if_to_id          (if_to_id),
        .if_excep          (if_excep)
    );

    inst_rom i_inst_rom (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata)
    );

endmodule

// ==== hdl/if_stage.sv ====
`timescale 1ns/100ps
`include "fetch_config.svh"

module if_stage (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     id_allowin,
    input  logic                     br_stall,
    input  logic                     if_flush,
    input  fetch_pkg::redirect_t     br,
    input  fetch_pkg::csr_redirect_t wb_csr,
    input  logic                     inst_sram_addr_ok,
    input  logic                     inst_sram_data_ok,
    input  logic [31:0]              inst_sram_rdata,
    output logic                     inst_sram_req,
    output logic [31:0]              inst_sram_addr,
    output logic                     if_to_id_valid,
    output fetch_pkg::if_to_id_t     if_to_id,
    output fetch_pkg::if_excep_t     if_excep
);
    logic                         fetch_en;
    logic [31:0]                  if_pc;
    logic [31:0]                  nextpc;
    logic                         redirect_pending;
    logic                         redirect;
    logic                         fetch_accept;
    logic                         fetch_enter;
    logic                         if_valid;
    logic                         if_ready_go;
    logic                         if_allowin;
    logic                         id_xfer;
    logic                         data_live;
    logic [`CANCEL_CNT_WIDTH-1:0] cancel_cnt;
    logic                         cancel_inc;
    logic                         cancel_dec;
    logic                         preif_cancel;
    logic                         hold_valid;
    logic [31:0]                  hold_inst;

    pc_redirect i_pc_redirect (
        .clk              (clk),
        .resetn           (resetn),
        .pc               (if_pc),
        .br               (br),
        .wb_csr           (wb_csr),
        .fetch_accept     (fetch_accept),
        .nextpc           (nextpc),
        .redirect_pending (redirect_pending)
    );

    assign redirect     = br.valid | wb_csr.ex_valid | wb_csr.ertn_valid;
    assign fetch_accept = inst_sram_req & inst_sram_addr_ok;
    // a request taken in the redirect cycle is dropped and refetched later
    assign fetch_enter  = fetch_accept & ~redirect;

    // response owned by IF: nothing stale ahead of it
    assign data_live   = inst_sram_data_ok & (cancel_cnt == '0) & ~preif_cancel;
    assign if_ready_go = hold_valid | data_live;
    assign if_to_id_valid = if_valid & if_ready_go & ~if_flush;
    assign id_xfer     = if_to_id_valid & id_allowin;
    assign if_allowin  = ~if_valid | id_xfer;

    // a known target lets fetch go on even while decode still holds br_stall
    assign inst_sram_req  = fetch_en & if_allowin & ~preif_cancel
                          & (~br_stall | redirect_pending);
    assign inst_sram_addr = nextpc;

    // keeps requests off until the first edge after reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_pc <= `FETCH_RESET_PC;
        end else if (fetch_enter) begin
            if_pc <= nextpc;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid <= 1'b0;
        end else if (if_allowin) begin
            if_valid <= fetch_enter;
        end else if (redirect) begin
            if_valid <= 1'b0;
        end
    end

    // the read IF waits on goes stale, its data_ok is swallowed later
    assign cancel_inc = redirect & if_valid & ~if_ready_go;
    assign cancel_dec = inst_sram_data_ok & (cancel_cnt != '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cancel_cnt <= '0;
        end else begin
            cancel_cnt <= cancel_cnt
                        + {{(`CANCEL_CNT_WIDTH-1){1'b0}}, cancel_inc}
                        - {{(`CANCEL_CNT_WIDTH-1){1'b0}}, cancel_dec};
        end
    end

    // no new request goes out until this response is gone
    always_ff @(posedge clk) begin
        if (!resetn) begin
            preif_cancel <= 1'b0;
        end else if (fetch_accept & redirect) begin
            preif_cancel <= 1'b1;
        end else if (inst_sram_data_ok & (cancel_cnt == '0)) begin
            preif_cancel <= 1'b0;
        end
    end

    // instruction parked while decode stalls
    always_ff @(posedge clk) begin
        if (!resetn) begin
            hold_valid <= 1'b0;
        end else if (id_xfer | redirect) begin
            hold_valid <= 1'b0;
        end else if (data_live) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_live & ~hold_valid) begin
            hold_inst <= inst_sram_rdata;
        end
    end

    assign if_to_id.inst = hold_valid ? hold_inst : inst_sram_rdata;
    assign if_to_id.pc   = if_pc;
    assign if_excep.adef = |if_pc[1:0];

endmodule

// ==== hdl/inst_rom.sv ====
`timescale 1ns/100ps
`include "fetch_config.svh"

module inst_rom #(
    parameter int LATENCY = `IMEM_LATENCY
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        inst_sram_req,
    input  logic [31:0] inst_sram_addr,
    output logic        inst_sram_addr_ok,
    output logic        inst_sram_data_ok,
    output logic [31:0] inst_sram_rdata
);
    localparam int IDX_W = $clog2(`IMEM_WORDS);
    localparam int CNT_W = $clog2(`IMEM_MAX_OUTSTANDING + 1);

    logic [31:0]      mem [`IMEM_WORDS];
    logic [CNT_W-1:0] in_flight;
    logic             accept;
    logic [LATENCY-1:0] pipe_valid;
    logic [31:0]      pipe_data [LATENCY];

    initial begin
        $readmemh("imem.hex", mem);
    end

    assign accept = inst_sram_req & inst_sram_addr_ok;

    // back-pressure once the limit is reached
    assign inst_sram_addr_ok = in_flight < `IMEM_MAX_OUTSTANDING;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + CNT_W'(accept) - CNT_W'(inst_sram_data_ok);
        end
    end

    // fixed latency, so responses leave in request order
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid[0] <= accept;
            for (int i = 1; i < LATENCY; i++) begin
                pipe_valid[i] <= pipe_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        pipe_data[0] <= mem[inst_sram_addr[IDX_W+1:2]];
        for (int i = 1; i < LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    assign inst_sram_data_ok = pipe_valid[LATENCY-1];
    assign inst_sram_rdata   = pipe_data[LATENCY-1];

endmodule

// ==== hdl/pc_redirect.sv ====
`timescale 1ns/100ps

module pc_redirect (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic [31:0]              pc,
    input  fetch_pkg::redirect_t     br,
    input  fetch_pkg::csr_redirect_t wb_csr,
    input  logic                     fetch_accept,
    output logic [31:0]              nextpc,
    output logic                     redirect_pending
);
    // bit 2 ertn, bit 1 exception, bit 0 branch
    logic [2:0]  live;
    logic [2:0]  held;
    logic [31:0] era_q;
    logic [31:0] ex_entry_q;
    logic [31:0] br_target_q;

    assign live = {wb_csr.ertn_valid, wb_csr.ex_valid, br.valid};

    // a source stays armed until the memory takes a request
    always_ff @(posedge clk) begin
        if (!resetn) begin
            held <= 3'b000;
        end else begin
            held <= live | (held & {3{~fetch_accept}});
        end
    end

    always_ff @(posedge clk) begin
        if (live[2]) begin
            era_q <= wb_csr.era;
        end
        if (live[1]) begin
            ex_entry_q <= wb_csr.ex_entry;
        end
        if (live[0]) begin
            br_target_q <= br.target;
        end
    end

    // writeback sources win over decode, held wins over live
    always_comb begin
        if (held[2]) begin
            nextpc = era_q;
        end else if (live[2]) begin
            nextpc = wb_csr.era;
        end else if (held[1]) begin
            nextpc = ex_entry_q;
        end else if (live[1]) begin
            nextpc = wb_csr.ex_entry;
        end else if (held[0]) begin
            nextpc = br_target_q;
        end else if (live[0]) begin
            nextpc = br.target;
        end else begin
            nextpc = pc + 32'd4;
        end
    end

    assign redirect_pending = |{live, held};

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the fetch testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module tb_fetch -o tb_fetch
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

# the ROM opens its image relative to the run directory
cp sim/imem.hex imem.hex
if [ $? -ne 0 ]; then
    echo "could not copy the ROM image"
    exit 1
fi

./obj_dir/tb_fetch +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== sim/fetch_properties.sv ====
`timescale 1ns/100ps

module fetch_properties (
    input logic                 clk,
    input logic                 resetn,
    input logic                 inst_sram_req,
    input logic                 inst_sram_addr_ok,
    input logic                 inst_sram_data_ok,
    input logic                 if_to_id_valid,
    input logic                 id_allowin,
    input logic                 if_flush,
    input fetch_pkg::if_to_id_t if_to_id
);
    logic [3:0] in_flight;
    logic       in_reset_q;
    int         fail_count;

    // reads accepted by the memory and not yet answered
    always_ff @(posedge clk) begin
        if (!resetn) begin
            in_flight <= 4'd0;
        end else begin
            in_flight <= in_flight + 4'(inst_sram_req & inst_sram_addr_ok)
                       - 4'(inst_sram_data_ok);
        end
    end

    always_ff @(posedge clk) begin
        in_reset_q <= !resetn;
    end

    a_no_orphan_data_ok: assert property (@(posedge clk) disable iff (!resetn)
        inst_sram_data_ok |-> in_flight != 4'd0)
        else begin
            $error("data_ok with no read in flight");
            fail_count++;
        end

    a_payload_stable: assert property (@(posedge clk) disable iff (!resetn)
        if_to_id_valid && !id_allowin |=> !if_to_id_valid || $stable(if_to_id))
        else begin
            $error("payload changed while decode stalled");
            fail_count++;
        end

    a_flush_blocks_valid: assert property (@(posedge clk)
        if_flush |-> !if_to_id_valid)
        else begin
            $error("if_to_id_valid high during if_flush");
            fail_count++;
        end

    a_no_req_in_reset: assert property (@(posedge clk)
        !resetn && in_reset_q |-> !inst_sram_req)
        else begin
            $error("inst_sram_req high during reset");
            fail_count++;
        end

endmodule

bind if_stage fetch_properties i_props (
    .clk               (clk),
    .resetn            (resetn),
    .inst_sram_req     (inst_sram_req),
    .inst_sram_addr_ok (inst_sram_addr_ok),
    .inst_sram_data_ok (inst_sram_data_ok),
    .if_to_id_valid    (if_to_id_valid),
    .id_allowin        (id_allowin),
    .if_flush          (if_flush),
    .if_to_id          (if_to_id)
);

// ==== sim/imem.hex ====
// one 32-bit instruction word per line, hex
// line n is word n, fetched for any pc with pc[5:2] == n
02bffc0c
0280040d
0010358e
001535cf
02803c10
5c000c0f
28c00191
29c00192
0040a193
02ffff8c
6400000c
50001000
03400000
1400002e
0380002f
4c000020

// ==== sim/tb_fetch.sv ====
`timescale 1ns/100ps
`include "fetch_config.svh"

module tb_fetch;
    localparam logic [31:0] START_PC = 32'h1c000000;
    localparam int RESET_CYCLES = 16;
    // cycle budget per test, summed
    localparam int TEST_BUDGET = RESET_CYCLES + 40 + 240 + 80 + 80 + 40 + 60;
    localparam fetch_pkg::redirect_t     NO_BR  = '0;
    localparam fetch_pkg::csr_redirect_t NO_CSR = '0;

    logic                     clk;
    logic                     resetn;
    fetch_pkg::redirect_t     br;
    logic                     br_stall;
    fetch_pkg::csr_redirect_t wb_csr;
    logic                     if_flush;
    logic                     id_allowin;
    logic                     if_to_id_valid;
    fetch_pkg::if_to_id_t     if_to_id;
    fetch_pkg::if_excep_t     if_excep;

    logic [31:0] exp_mem [`IMEM_WORDS];
    logic [31:0] model_pc;
    logic [31:0] lfsr;
    int          mismatches;
    int          failures;
    int          transfers;

    fetch_top i_dut (
        .clk            (clk),
        .resetn         (resetn),
        .br             (br),
        .br_stall       (br_stall),
        .wb_csr         (wb_csr),
        .if_flush       (if_flush),
        .id_allowin     (id_allowin),
        .if_to_id_valid (if_to_id_valid),
        .if_to_id       (if_to_id),
        .if_excep       (if_excep)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic random_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic fetch_pkg::redirect_t make_br(input logic [31:0] target);
        fetch_pkg::redirect_t b;
        b.valid  = 1'b1;
        b.target = target;
        return b;
    endfunction

    function automatic fetch_pkg::csr_redirect_t make_csr(input logic ertn, input logic ex,
                                                          input logic [31:0] entry,
                                                          input logic [31:0] era);
        fetch_pkg::csr_redirect_t w;
        w.ertn_valid = ertn;
        w.ex_valid   = ex;
        w.ex_entry   = entry;
        w.era        = era;
        return w;
    endfunction

    task automatic check_payload(input fetch_pkg::if_to_id_t got,
                                 input fetch_pkg::if_to_id_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH if_to_id: got inst %h pc %h, expected inst %h pc %h",
                     got.inst, got.pc, exp.inst, exp.pc);
        end
    endtask

    task automatic check_excep(input fetch_pkg::if_excep_t got,
                               input fetch_pkg::if_excep_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH if_excep: got %h expected %h", got, exp);
        end
    endtask

    // drive 10 ns after the edge, sample 10 ns before the next one
    task automatic run_cycle(input logic allow, input fetch_pkg::redirect_t b,
                             input fetch_pkg::csr_redirect_t w, input logic flush);
        fetch_pkg::if_to_id_t exp;
        fetch_pkg::if_excep_t exp_ex;
        @(posedge clk);
        #10;
        id_allowin = allow;
        br         = b;
        wb_csr     = w;
        if_flush   = flush;
        #80;
        if (flush && if_to_id_valid) begin
            failures++;
            $display("decode saw a valid item while if_flush was high");
        end
        if (if_to_id_valid && id_allowin) begin
            exp.inst    = exp_mem[model_pc[5:2]];
            exp.pc      = model_pc;
            exp_ex.adef = |model_pc[1:0];
            check_payload(if_to_id, exp);
            check_excep(if_excep, exp_ex);
            model_pc = model_pc + 32'd4;
            transfers++;
        end
        // ertn beats exception beats branch
        if (w.ertn_valid) begin
            model_pc = w.era;
        end else if (w.ex_valid) begin
            model_pc = w.ex_entry;
        end else if (b.valid) begin
            model_pc = b.target;
        end
    endtask

    task automatic stream(input int count, input logic random_allow);
        int start;
        start = transfers;
        while (transfers - start < count) begin
            run_cycle(random_allow ? random_bit() : 1'b1, NO_BR, NO_CSR, 1'b0);
        end
    endtask

    task automatic test_sequential();
        stream(12, 1'b0);
    endtask

    task automatic test_backpressure();
        stream(40, 1'b1);
    endtask

    task automatic test_branch();
        stream(5, 1'b1);
        run_cycle(random_bit(), make_br(32'h1c000020), NO_CSR, 1'b0);
        stream(10, 1'b1);
    endtask

    task automatic test_priority();
        run_cycle(random_bit(), make_br(32'h1c000080),
                  make_csr(1'b1, 1'b1, 32'h1c000100, 32'h1c000040), 1'b0);
        stream(6, 1'b1);
        run_cycle(random_bit(), make_br(32'h1c000080),
                  make_csr(1'b0, 1'b1, 32'h1c000100, 32'h1c000040), 1'b0);
        stream(6, 1'b1);
    endtask

    task automatic test_misaligned();
        run_cycle(random_bit(), make_br(32'h1c000016), NO_CSR, 1'b0);
        stream(4, 1'b1);
    endtask

    task automatic test_flush();
        run_cycle(random_bit(), NO_BR, make_csr(1'b0, 1'b1, 32'h1c000030, 32'h0), 1'b1);
        run_cycle(random_bit(), NO_BR, NO_CSR, 1'b1);
        run_cycle(random_bit(), NO_BR, NO_CSR, 1'b1);
        stream(8, 1'b1);
    endtask

    initial begin
        resetn     = 1'b0;
        br         = NO_BR;
        br_stall   = 1'b0;
        wb_csr     = NO_CSR;
        if_flush   = 1'b0;
        id_allowin = 1'b0;
        lfsr       = 32'hb059a4fe;
        mismatches = 0;
        failures   = 0;
        transfers  = 0;
        model_pc   = START_PC;
        $readmemh("sim/imem.hex", exp_mem);
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        resetn = 1'b1;
        test_sequential();
        test_backpressure();
        test_branch();
        test_priority();
        test_misaligned();
        test_flush();
        failures = failures + i_dut.i_if_stage.i_props.fail_count;
        $display("errors: %0d mismatches, %0d other failures, %0d transfers checked",
                 mismatches, failures, transfers);
        if (mismatches + failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(2 * TEST_BUDGET * 100);
        $display("watchdog: run did not finish within %0d cycles", 2 * TEST_BUDGET);
        $display("TB FAILED");
        $finish;
    end

endmodule
